//--- src/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define TAG_W        4
`define XLEN         32
`define ALU_RS_DEPTH 2
`define MUL_RS_DEPTH 1
`define MUL_STAGES   3

`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011

`endif

//--- src/ooo_pkg.sv
`default_nettype none

`include "ooo_consts.svh"

package ooo_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same word, two views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL
    } op_e;

    typedef struct packed {
        logic              ready;
        logic [`TAG_W-1:0] tag;   // Producer tag while not ready
        logic [`XLEN-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [`TAG_W-1:0] dest_tag;
        operand_t          src1;
        operand_t          src2;
    } rs_entry_t;

endpackage

`default_nettype wire

//--- src/cdb_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

interface cdb_if;
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0]  data;

    // Arbiter side
    modport master (
        output valid, tag, data
    );

    // Stations and register unit
    modport listen (
        input valid, tag, data
    );
endinterface

`default_nettype wire

//--- src/rsv_station.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module rsv_station #(
    parameter int DEPTH = 2
) (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                write,
    input  wire ooo_pkg::rs_entry_t  new_entry,
    cdb_if.listen                    cdb,
    input  wire logic                unit_ready,
    output logic                     full,
    output logic                     issue_valid,
    output ooo_pkg::rs_entry_t       issue_entry
);
    localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Slot 0 is the oldest, queue kept compacted
    ooo_pkg::rs_entry_t slots [DEPTH];
    ooo_pkg::rs_entry_t woken [DEPTH];
    ooo_pkg::rs_entry_t nxt   [DEPTH];
    ooo_pkg::rs_entry_t incoming;
    logic               found;
    logic [SEL_W-1:0]   sel;
    logic               placed;

    function automatic ooo_pkg::operand_t snoop(
        input ooo_pkg::operand_t src,
        input logic              bv,
        input logic [`TAG_W-1:0] bt,
        input logic [`XLEN-1:0]  bd
    );
        ooo_pkg::operand_t o;
        o = src;
        if (!src.ready && bv && src.tag == bt) begin
            o.ready = 1'b1;
            o.value = bd;
        end
        return o;
    endfunction

    // Oldest entry with both operands in hand
    always_comb begin
        found = 1'b0;
        sel = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (slots[i].valid && slots[i].src1.ready && slots[i].src2.ready) begin
                found = 1'b1;
                sel = SEL_W'(i);
            end
        end
    end

    assign issue_valid = found && unit_ready;
    assign issue_entry = slots[sel];
    assign full = slots[DEPTH-1].valid; // Compacted, so top slot decides

    always_comb begin
        placed = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            woken[i] = slots[i];
            woken[i].src1 = snoop(slots[i].src1, cdb.valid, cdb.tag, cdb.data);
            woken[i].src2 = snoop(slots[i].src2, cdb.valid, cdb.tag, cdb.data);
        end

        // Same-cycle broadcast goes straight into the new entry
        incoming = new_entry;
        incoming.src1 = snoop(new_entry.src1, cdb.valid, cdb.tag, cdb.data);
        incoming.src2 = snoop(new_entry.src2, cdb.valid, cdb.tag, cdb.data);

        for (int i = 0; i < DEPTH - 1; i++) begin
            nxt[i] = (issue_valid && i >= sel) ? woken[i+1] : woken[i];
        end
        nxt[DEPTH-1] = woken[DEPTH-1];
        if (issue_valid)
            nxt[DEPTH-1].valid = 1'b0;

        for (int i = 0; i < DEPTH; i++) begin
            if (write && !placed && !nxt[i].valid) begin
                nxt[i] = incoming;
                nxt[i].valid = 1'b1;
                placed = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slots[i] <= nxt[i];
            if (reset)
                slots[i].valid <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> issue_entry.valid && issue_entry.src1.ready && issue_entry.src2.ready);

    // Dispatch side must respect full
    assert property (@(posedge clk) disable iff (reset) write |-> !full);

endmodule

`default_nettype wire

//--- src/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module alu_unit (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               issue_valid,
    input  wire ooo_pkg::rs_entry_t issue_entry,
    input  wire logic               grant,
    output logic                    ready,
    output logic                    req,
    output logic [`TAG_W-1:0]       res_tag,
    output logic [`XLEN-1:0]        res_data
);
    logic              held;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
    logic [`XLEN-1:0]  result;

    assign a = issue_entry.src1.value;
    assign b = issue_entry.src2.value;

    always_comb begin
        case (issue_entry.op)
            ooo_pkg::OP_SUB: result = a - b;
            ooo_pkg::OP_AND: result = a & b;
            ooo_pkg::OP_OR:  result = a | b;
            ooo_pkg::OP_XOR: result = a ^ b;
            default:         result = a + b;
        endcase
    end

    assign ready = !held || grant; // Register frees on the grant edge
    assign req = held;

    always_ff @(posedge clk) begin
        if (reset)
            held <= 1'b0;
        else if (issue_valid)
            held <= 1'b1;
        else if (grant)
            held <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res_tag <= issue_entry.dest_tag;
            res_data <= result;
        end
    end

    // Losing arbitration keeps the result untouched
    assert property (@(posedge clk) disable iff (reset)
        req && !grant |=> req && $stable(res_tag) && $stable(res_data));

endmodule

`default_nettype wire

//--- src/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module mul_unit (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               issue_valid,
    input  wire ooo_pkg::rs_entry_t issue_entry,
    output logic                    req,
    output logic [`TAG_W-1:0]       res_tag,
    output logic [`XLEN-1:0]        res_data
);
    logic [`MUL_STAGES-1:0] vld;
    logic [`TAG_W-1:0]      tag_q  [`MUL_STAGES];
    logic [`XLEN-1:0]       prod_q [`MUL_STAGES-1];
    logic [`XLEN-1:0]       part_lo;
    logic [15:0]            part_hi;  // Only low half survives the shift

    always_ff @(posedge clk) begin
        if (reset)
            vld <= '0;
        else
            vld <= {vld[`MUL_STAGES-2:0], issue_valid};
    end

    always_ff @(posedge clk) begin
        // Stage 1 partial products
        part_lo <= issue_entry.src1.value * issue_entry.src2.value[15:0];
        part_hi <= issue_entry.src1.value[15:0] * issue_entry.src2.value[31:16];
        tag_q[0] <= issue_entry.dest_tag;

        prod_q[0] <= part_lo + {part_hi, 16'd0};
        for (int s = 1; s < `MUL_STAGES - 1; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
        for (int s = 1; s < `MUL_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
    end

    assign req = vld[`MUL_STAGES-1];
    assign res_tag = tag_q[`MUL_STAGES-1];
    assign res_data = prod_q[`MUL_STAGES-2];

endmodule

`default_nettype wire

//--- src/cdb_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module cdb_arbiter (
    input  wire logic              alu_req,
    input  wire logic [`TAG_W-1:0] alu_tag,
    input  wire logic [`XLEN-1:0]  alu_data,
    input  wire logic              mul_req,
    input  wire logic [`TAG_W-1:0] mul_tag,
    input  wire logic [`XLEN-1:0]  mul_data,
    output logic                   alu_grant,
    cdb_if.master                  cdb
);
    // Multiplier pipeline cannot stall, so it always wins
    assign alu_grant = alu_req && !mul_req;

    assign cdb.valid = mul_req || alu_req;
    assign cdb.tag = mul_req ? mul_tag : alu_tag;
    assign cdb.data = mul_req ? mul_data : alu_data;

    always_comb begin
        assert #0 (!(mul_req && alu_grant));
    end

endmodule

`default_nettype wire

//--- src/reg_status.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module reg_status (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               dispatch_valid,
    input  wire ooo_pkg::inst_u     dispatch_inst,
    cdb_if.listen                   cdb,
    input  wire logic               alu_full,
    input  wire logic               mul_full,
    output logic                    dispatch_ready,
    output logic                    alu_write,
    output logic                    mul_write,
    output ooo_pkg::rs_entry_t      new_entry
);
    logic [`XLEN-1:0]  regs    [32];
    logic [`TAG_W-1:0] reg_tag [32];
    logic [31:0]       busy;
    logic [`TAG_W-1:0] next_tag;
    ooo_pkg::op_e      op;
    logic              is_imm;
    logic              is_mul;
    logic              accept;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;

    function automatic ooo_pkg::operand_t lookup(
        input logic              b,
        input logic [`TAG_W-1:0] t,
        input logic [`XLEN-1:0]  v,
        input logic              cv,
        input logic [`TAG_W-1:0] ct,
        input logic [`XLEN-1:0]  cd
    );
        ooo_pkg::operand_t o;
        o.ready = !b;
        o.tag = t;
        o.value = v;
        if (b && cv && ct == t) begin // Producer broadcasting right now
            o.ready = 1'b1;
            o.value = cd;
        end
        return o;
    endfunction

    assign rd = dispatch_inst.r_fmt.rd;
    assign rs1 = dispatch_inst.r_fmt.rs1;
    assign rs2 = dispatch_inst.r_fmt.rs2;
    assign is_imm = dispatch_inst.i_fmt.opcode == `OPC_OP_IMM;

    always_comb begin
        op = ooo_pkg::OP_ADD;
        if (!is_imm && dispatch_inst.r_fmt.funct7 == 7'b0000001) begin
            op = ooo_pkg::OP_MUL;
        end else if (!is_imm) begin
            case (dispatch_inst.r_fmt.funct3)
                3'b000: op = dispatch_inst.r_fmt.funct7[5] ? ooo_pkg::OP_SUB : ooo_pkg::OP_ADD;
                3'b100: op = ooo_pkg::OP_XOR;
                3'b110: op = ooo_pkg::OP_OR;
                3'b111: op = ooo_pkg::OP_AND;
                default: op = ooo_pkg::OP_ADD;
            endcase
        end
    end

    assign is_mul = op == ooo_pkg::OP_MUL;
    assign dispatch_ready = is_mul ? !mul_full : !alu_full;
    assign accept = dispatch_valid && dispatch_ready;
    assign alu_write = accept && !is_mul;
    assign mul_write = accept && is_mul;

    always_comb begin
        new_entry.valid = 1'b1;
        new_entry.op = op;
        new_entry.dest_tag = next_tag;
        new_entry.src1 = lookup(busy[rs1], reg_tag[rs1], regs[rs1],
                                cdb.valid, cdb.tag, cdb.data);
        if (is_imm) begin
            new_entry.src2.ready = 1'b1;
            new_entry.src2.tag = '0;
            new_entry.src2.value = {{20{dispatch_inst.i_fmt.imm12[11]}},
                                    dispatch_inst.i_fmt.imm12};
        end else begin
            new_entry.src2 = lookup(busy[rs2], reg_tag[rs2], regs[rs2],
                                    cdb.valid, cdb.tag, cdb.data);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            next_tag <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin
                if (cdb.valid && busy[i] && reg_tag[i] == cdb.tag) begin
                    regs[i] <= cdb.data;
                    busy[i] <= 1'b0;
                end
            end
            // New rename overrides a clear in the same cycle
            if (accept) begin
                next_tag <= next_tag + 1'b1;
                if (rd != 5'd0) begin
                    busy[rd] <= 1'b1;
                    reg_tag[rd] <= next_tag;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !busy[0]);

endmodule

`default_nettype wire

//--- src/ooo_core_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module ooo_core_top (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        dispatch_valid,
    input  wire logic [31:0] dispatch_inst,
    output logic             dispatch_ready,
    output logic             wb_valid,
    output logic [`TAG_W-1:0] wb_tag,
    output logic [`XLEN-1:0] wb_data
);
    cdb_if cdb ();

    ooo_pkg::rs_entry_t new_entry;
    ooo_pkg::rs_entry_t alu_issue_entry;
    ooo_pkg::rs_entry_t mul_issue_entry;
    logic               alu_write, mul_write;
    logic               alu_full, mul_full;
    logic               alu_issue_valid, mul_issue_valid;
    logic               alu_ready, alu_req, alu_grant, mul_req;
    logic [`TAG_W-1:0]  alu_tag, mul_tag;
    logic [`XLEN-1:0]   alu_data, mul_data;

    reg_status u_reg_status (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .cdb            (cdb),
        .alu_full       (alu_full),
        .mul_full       (mul_full),
        .dispatch_ready (dispatch_ready),
        .alu_write      (alu_write),
        .mul_write      (mul_write),
        .new_entry      (new_entry)
    );

    rsv_station #(.DEPTH(`ALU_RS_DEPTH)) u_alu_rs (
        .clk         (clk),
        .reset       (reset),
        .write       (alu_write),
        .new_entry   (new_entry),
        .cdb         (cdb),
        .unit_ready  (alu_ready),
        .full        (alu_full),
        .issue_valid (alu_issue_valid),
        .issue_entry (alu_issue_entry)
    );

    rsv_station #(.DEPTH(`MUL_RS_DEPTH)) u_mul_rs (
        .clk         (clk),
        .reset       (reset),
        .write       (mul_write),
        .new_entry   (new_entry),
        .cdb         (cdb),
        .unit_ready  (1'b1),  // Pipeline takes one per cycle
        .full        (mul_full),
        .issue_valid (mul_issue_valid),
        .issue_entry (mul_issue_entry)
    );

    alu_unit u_alu (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (alu_issue_valid),
        .issue_entry (alu_issue_entry),
        .grant       (alu_grant),
        .ready       (alu_ready),
        .req         (alu_req),
        .res_tag     (alu_tag),
        .res_data    (alu_data)
    );

    mul_unit u_mul (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (mul_issue_valid),
        .issue_entry (mul_issue_entry),
        .req         (mul_req),
        .res_tag     (mul_tag),
        .res_data    (mul_data)
    );

    cdb_arbiter u_arb (
        .alu_req   (alu_req),
        .alu_tag   (alu_tag),
        .alu_data  (alu_data),
        .mul_req   (mul_req),
        .mul_tag   (mul_tag),
        .mul_data  (mul_data),
        .alu_grant (alu_grant),
        .cdb       (cdb)
    );

    assign wb_valid = cdb.valid;
    assign wb_tag = cdb.tag;
    assign wb_data = cdb.data;

endmodule

`default_nettype wire

//--- verif/tb_ooo_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "ooo_consts.svh"

module tb_ooo_core;
    localparam string INPUT_FILE  = "verif/ooo_input.txt";
    localparam int    MAX_RECORDS = 64;
    localparam int    PASSES      = 2;   // Back-to-back first, then random gaps
    localparam int    NUM_TAGS    = 1 << `TAG_W;

    logic              clk;
    logic              reset;
    logic              dispatch_valid;
    logic [31:0]       dispatch_inst;
    logic              dispatch_ready;
    logic              wb_valid;
    logic [`TAG_W-1:0] wb_tag;
    logic [`XLEN-1:0]  wb_data;

    logic [31:0]       rec_inst [MAX_RECORDS];
    logic [`XLEN-1:0]  rec_exp  [MAX_RECORDS];
    logic [`XLEN-1:0]  expected [NUM_TAGS];
    logic              pending  [NUM_TAGS];
    logic [`TAG_W-1:0] tag_ctr;
    int                n_records;
    int                errors;
    int                accepted;
    int                writebacks;
    int                stall_cycles;
    int                cycles;
    int                cycle_limit;
    logic              limit_set;

    ooo_core_top uut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .dispatch_ready (dispatch_ready),
        .wb_valid       (wb_valid),
        .wb_tag         (wb_tag),
        .wb_data        (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic load_records();
        int               fd;
        string            line;
        logic [31:0]      word;
        logic [`XLEN-1:0] value;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %s", INPUT_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#" && n_records < MAX_RECORDS) begin
                    if ($sscanf(line, "%h %h", word, value) == 2) begin
                        rec_inst[n_records] = word;
                        rec_exp[n_records] = value;
                        n_records++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_records == 0) begin
            $display("No stimulus records were read");
            errors++;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        dispatch_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        tag_ctr = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        if (wb_valid !== 1'b0) begin
            $display("[ERROR] %0t ns: wb_valid expected 0, got %b", $time, wb_valid);
            errors++;
        end
        if (dispatch_ready !== 1'b1) begin
            $display("[ERROR] %0t ns: dispatch_ready expected 1, got %b", $time, dispatch_ready);
            errors++;
        end
    endtask

    // Tags follow dispatch order, wrapping at 16
    task automatic note_dispatch(input logic [`XLEN-1:0] exp_value);
        if (pending[tag_ctr]) begin
            $display("[%0t] Tag %0d was handed out again before its writeback", $time, tag_ctr);
            errors++;
        end
        expected[tag_ctr] = exp_value;
        pending[tag_ctr] = 1'b1;
        tag_ctr = tag_ctr + 1'b1;
        accepted++;
    endtask

    task automatic run_pass(input logic use_gaps);
        int gap;
        for (int i = 0; i < n_records; i++) begin
            gap = use_gaps ? int'($urandom % 4) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            dispatch_valid = 1'b1;
            dispatch_inst = rec_inst[i];
            @(negedge clk);
            while (dispatch_ready !== 1'b1) begin
                stall_cycles++;
                @(negedge clk);
            end
            @(posedge clk);   // Accepted on this edge
            #1;
            note_dispatch(rec_exp[i]);
            dispatch_valid = 1'b0;
        end
    endtask

    function automatic int count_pending();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t])
                n++;
        end
        return n;
    endfunction

    task automatic check_writeback();
        if (!pending[wb_tag]) begin
            $display("[%0t] Writeback for tag %0d, which has no instruction in flight",
                     $time, wb_tag);
            errors++;
        end else begin
            if (wb_data !== expected[wb_tag]) begin
                $display("[ERROR] %0t ns: wb_data for tag %0d expected %h, got %h",
                         $time, wb_tag, expected[wb_tag], wb_data);
                errors++;
            end
            pending[wb_tag] = 1'b0;
        end
        writebacks++;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset === 1'b0 && wb_valid === 1'b1)
            check_writeback();
    end

    initial begin
        cycles = 0;
        wait (limit_set === 1'b1);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d writebacks still missing",
                 cycles, count_pending());
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h91bb));
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_inst = '0;
        tag_ctr = '0;
        n_records = 0;
        errors = 0;
        accepted = 0;
        writebacks = 0;
        stall_cycles = 0;
        limit_set = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
            expected[t] = '0;
        end

        load_records();
        cycle_limit = PASSES * (20 * n_records + 100);
        limit_set = 1'b1;

        for (int p = 0; p < PASSES; p++) begin
            apply_reset();
            stall_cycles = 0;
            run_pass(p != 0);
            // Station depths are small enough that back-to-back records must stall
            if (p == 0 && n_records > 0 && stall_cycles == 0) begin
                $display("dispatch_ready never dropped during back-to-back dispatch");
                errors++;
            end
            while (count_pending() != 0) @(posedge clk);
            repeat (8) @(posedge clk);  // Catch late duplicates
            #1;
        end

        if (writebacks != accepted) begin
            $display("Saw %0d writebacks for %0d accepted instructions", writebacks, accepted);
            errors++;
        end

        $display("Accepted %0d, writebacks %0d, errors %0d", accepted, writebacks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/ooo_input.txt
# instruction word (hex), expected writeback value (hex)
# values come from in-order execution starting with all registers zero
00500093 00000005
FFD00113 FFFFFFFD
002081B3 00000002
02118233 0000000A
402082B3 00000008
0020C333 FFFFFFF8
022103B3 00000009
00537433 00000008
007264B3 0000000B
06408013 00000069
00300533 00000002
029485B3 00000079
02610633 00000018
F8758693 00000000
40B60733 FFFFFF9F
025707B3 FFFFFCF8
00A780B3 FFFFFCFA
0000C133 FFFFFCFA

//--- files.f
+incdir+src
src/ooo_pkg.sv
src/cdb_if.sv
src/rsv_station.sv
src/alu_unit.sv
src/mul_unit.sv
src/cdb_arbiter.sv
src/reg_status.sv
src/ooo_core_top.sv
verif/tb_ooo_core.sv

//--- Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - src

sources:
  - files:
      - src/ooo_pkg.sv
      - src/cdb_if.sv
      - src/rsv_station.sv
      - src/alu_unit.sv
      - src/mul_unit.sv
      - src/cdb_arbiter.sv
      - src/reg_status.sv
      - src/ooo_core_top.sv
  - target: test
    files:
      - verif/tb_ooo_core.sv
